/* compile.f */
+incdir+include
rtl/sram_pkg.sv
rtl/sync_fifo.sv
rtl/wb_bank_decode.sv
rtl/wb_sram_bank.sv
rtl/wb_resp_merge.sv
rtl/wb_sram_array.sv
tb/sram_chip_model.sv
tb/tb_wb_sram_array.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it; exits 1 if the log shows a failure
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f compile.f \
    --top-module tb_wb_sram_array \
    -Mdir obj_dir -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
exit "$status"

/* tb/tb_wb_sram_array.sv */
/* Testbench for the Wishbone SRAM bank array. Drives pipelined traffic, predicts
   every read from a shadow memory and checks the acknowledges in request order */
`default_nettype none
`timescale 1ns/1ns

`include "sram_defs.svh"

module tb_wb_sram_array
    import sram_pkg::*;
();

    localparam logic [31:0] BASE       = `SRAM_BASE_ADDR;
    localparam logic [31:0] SPAN       = `SRAM_BANK_SPAN;
    localparam logic [31:0] TOTAL_SPAN = SPAN * `SRAM_NUM_BANKS;
    localparam int          N_RANDOM   = 200;
    localparam int          TOTAL_REQ  = 16 + 16 + 16 + N_RANDOM + 6 + 4;
    localparam int          WATCHDOG_CYCLES = 20 * TOTAL_REQ + 100;

    typedef struct packed {
        logic        is_read;
        logic [1:0]  sel;
        logic [31:0] addr;
        logic [15:0] data;      // Expected read data after the select mask
    } exp_t;

    logic        i_wb_clk;
    logic        i_wb_rst;
    logic        i_wb_cyc;
    logic        i_wb_stb;
    logic        i_wb_we;
    logic [1:0]  i_wb_sel;
    logic [31:0] i_wb_addr;
    logic [15:0] i_wb_data;
    logic [15:0] o_wb_data;
    logic        o_wb_ack;
    logic        o_wb_stall;
    sram_pins_t  sram_pins [`SRAM_NUM_BANKS];
    wire  [`SRAM_NUM_BANKS-1:0][`SRAM_DATA_WIDTH-1:0] sram_dq;

    logic [7:0]  shadow [int unsigned];     // Written bytes by array offset
    exp_t        exp_q [$];
    integer      seed = 32'hc345;
    int          error_count = 0;
    int          req_count = 0;
    int          ack_count = 0;

    wb_sram_array i_dut (
        .i_wb_clk    (i_wb_clk),
        .i_wb_rst    (i_wb_rst),
        .i_wb_cyc    (i_wb_cyc),
        .i_wb_stb    (i_wb_stb),
        .i_wb_we     (i_wb_we),
        .i_wb_sel    (i_wb_sel),
        .i_wb_addr   (i_wb_addr),
        .i_wb_data   (i_wb_data),
        .o_wb_data   (o_wb_data),
        .o_wb_ack    (o_wb_ack),
        .o_wb_stall  (o_wb_stall),
        .o_sram_pins (sram_pins),
        .io_sram_dq  (sram_dq)
    );

    for (genvar g = 0; g < `SRAM_NUM_BANKS; g++) begin : g_chip
        sram_chip_model #(.BANK(g)) u_chip (
            .i_wb_clk (i_wb_clk),
            .i_pins   (sram_pins[g]),
            .io_dq    (sram_dq[g])
        );
    end

    initial begin
        i_wb_clk = 1'b0;
        forever #2 i_wb_clk = ~i_wb_clk;
    end

    // Contents of a byte nobody has written yet
    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ {2'b00, a[21:16]} ^ 8'h3c;
    endfunction

    function automatic logic [7:0] shadow_byte(input logic [31:0] ofs);
        return shadow.exists(ofs) ? shadow[ofs] : fill_byte(ofs);
    endfunction

    // Byte at ofs on bits 7:0, next byte on bits 15:8
    function automatic logic [15:0] ref_access(input logic we, input logic [31:0] ofs,
                                               input logic [1:0] sel, input logic [15:0] data);
        logic [15:0] rd;
        rd = 16'h0000;
        if (we) begin
            if (sel[0]) shadow[ofs] = data[7:0];
            if (sel[1]) shadow[ofs + 32'd1] = data[15:8];
        end else begin
            if (sel[0]) rd[7:0] = shadow_byte(ofs);
            if (sel[1]) rd[15:8] = shadow_byte(ofs + 32'd1);
        end
        return rd;
    endfunction

    // Holds STB through STALL until the rising edge after this task accepts it
    task automatic issue(input logic we, input logic [31:0] addr,
                         input logic [1:0] sel, input logic [15:0] data);
        exp_t        e;
        logic [31:0] ofs;
        @(posedge i_wb_clk);
        i_wb_stb  <= 1'b1;
        i_wb_we   <= we;
        i_wb_sel  <= sel;
        i_wb_addr <= addr;
        i_wb_data <= data;
        do begin
            @(negedge i_wb_clk);
        end while (o_wb_stall !== 1'b0);
        ofs = addr - BASE;
        if (addr >= BASE && ofs < TOTAL_SPAN) begin    // Out of range never acks
            e.is_read = !we;
            e.sel     = sel;
            e.addr    = addr;
            e.data    = ref_access(we, ofs, sel, data);
            exp_q.push_back(e);
            req_count++;
        end
    endtask

    task automatic release_strobe();
        @(posedge i_wb_clk);
        i_wb_stb <= 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(negedge i_wb_clk);
    endtask

    always @(negedge i_wb_clk) begin : compare_resp
        exp_t        e;
        logic [15:0] mask;
        if (o_wb_ack === 1'b1) begin
            ack_count++;
            if (exp_q.size() == 0) begin
                $display("Acknowledge at t=%0t with no request outstanding", $time);
                error_count++;
            end else begin
                e    = exp_q.pop_front();
                mask = {{8{e.sel[1]}}, {8{e.sel[0]}}};
                if (e.is_read && (o_wb_data & mask) !== e.data) begin
                    $display("FAILED t=%0t o_wb_data: got %h expected %h at address %h",
                             $time, o_wb_data & mask, e.data, e.addr);
                    error_count++;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge i_wb_clk);
        $display("Timeout after %0d cycles with %0d responses outstanding",
                 WATCHDOG_CYCLES, exp_q.size());
        $display("errors %0d, requests %0d, acknowledges %0d", error_count, req_count, ack_count);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] unal_ofs [4];
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] ofs;
        int          acks_before;
        unal_ofs  = '{32'h81, 32'h85, 32'h107, TOTAL_SPAN - 32'd3};
        i_wb_rst  = 1'b1;
        i_wb_cyc  = 1'b0;
        i_wb_stb  = 1'b0;
        i_wb_we   = 1'b0;
        i_wb_sel  = 2'b00;
        i_wb_addr = 32'h0;
        i_wb_data = 16'h0;
        // Every cycle up to the first strobe, CYC rises two cycles before it
        for (int n = 0; n < 6; n++) begin
            @(negedge i_wb_clk);
            if (o_wb_ack !== 1'b0 || o_wb_stall !== 1'b0) begin
                $display("FAILED t=%0t o_wb_ack/o_wb_stall: got %b/%b expected 0/0",
                         $time, o_wb_ack, o_wb_stall);
                error_count++;
            end
            if (n == 0) begin
                @(posedge i_wb_clk);
                i_wb_rst <= 1'b0;
            end else if (n == 4) begin
                @(posedge i_wb_clk);
                i_wb_cyc <= 1'b1;
            end
        end

        // Aligned words in bank 0
        for (int n = 0; n < 8; n++) begin
            r = $random(seed);
            issue(1'b1, BASE + 32'h100 + 2 * n, 2'b11, r[15:0]);
        end
        for (int n = 0; n < 8; n++) issue(1'b0, BASE + 32'h100 + 2 * n, 2'b11, 16'h0000);
        release_strobe();
        drain();

        // Single byte lanes in bank 1 where sel 00 writes nothing
        for (int n = 0; n < 4; n++) begin
            r = $random(seed);
            a = BASE + SPAN + 32'h200 + 2 * n;
            issue(1'b1, a, 2'b11, r[15:0]);
            issue(1'b1, a, n[1:0], r[31:16]);
        end
        for (int n = 0; n < 4; n++) begin
            a = BASE + SPAN + 32'h200 + 2 * n;
            issue(1'b0, a, 2'b11, 16'h0000);
            issue(1'b0, a, n[1:0], 16'h0000);
        end
        release_strobe();
        drain();

        // Odd addresses with the last one ending on the final word of bank 1
        for (int n = 0; n < 4; n++) begin
            r = $random(seed);
            issue(1'b1, BASE + unal_ofs[n], (n == 0 || n == 3) ? 2'b11 : n[1:0], r[15:0]);
        end
        for (int n = 0; n < 4; n++) begin
            issue(1'b0, BASE + unal_ofs[n] - 32'd1, 2'b11, 16'h0000);
            issue(1'b0, BASE + unal_ofs[n], 2'b11, 16'h0000);
            issue(1'b0, BASE + unal_ofs[n] + 32'd1, 2'b11, 16'h0000);
        end
        release_strobe();
        drain();

        // Random traffic near both ends of both banks
        for (int n = 0; n < N_RANDOM; n++) begin
            r   = $random(seed);
            ofs = r[0] ? SPAN : 32'h0;
            ofs = ofs + (r[1] ? SPAN - 32'd2 - {26'h0, r[10:5]} : {26'h0, r[10:5]});
            issue(r[2], BASE + ofs, r[4:3], r[31:16]);
        end
        release_strobe();
        drain();
        if (ack_count != req_count) begin
            $display("FAILED t=%0t ack_count: got %0d expected %0d", $time, ack_count, req_count);
            error_count++;
        end

        // Drop CYC with reads still queued
        for (int n = 0; n < 6; n++) issue(1'b0, BASE + SPAN + 32'h200 + 2 * n, 2'b11, 16'h0000);
        @(posedge i_wb_clk);
        i_wb_cyc <= 1'b0;
        i_wb_stb <= 1'b0;
        exp_q.delete();
        acks_before = ack_count;
        repeat (10) @(negedge i_wb_clk);
        if (ack_count != acks_before) begin
            $display("Acknowledge arrived after CYC was dropped");
            error_count++;
        end
        @(posedge i_wb_clk);
        i_wb_cyc <= 1'b1;

        // Outside the span and then one read to show the bus still works
        issue(1'b0, BASE - 32'd2, 2'b11, 16'h0000);
        issue(1'b1, BASE + TOTAL_SPAN, 2'b11, 16'hdead);
        issue(1'b0, 32'hffff_fffe, 2'b11, 16'h0000);
        release_strobe();
        acks_before = ack_count;
        repeat (10) @(negedge i_wb_clk);
        if (ack_count != acks_before) begin
            $display("Out-of-range request was acknowledged");
            error_count++;
        end
        issue(1'b0, BASE + 32'h100, 2'b11, 16'h0000);
        release_strobe();
        drain();

        $display("errors %0d, requests %0d, acknowledges %0d", error_count, req_count, ack_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/sram_chip_model.sv */
/* Behavioral IS61WV102416 chip for the testbench, one instance per bank.
   Reads are combinational, writes land at the clock edge that ends the access */
`default_nettype none
`timescale 1ns/1ns

`include "sram_defs.svh"

module sram_chip_model
    import sram_pkg::*;
#(
    parameter int BANK = 0      // Chip number, offsets the fill pattern
) (
    input  logic                        i_wb_clk,
    input  sram_pins_t                  i_pins,
    inout  wire  [`SRAM_DATA_WIDTH-1:0] io_dq
);

    logic [`SRAM_DATA_WIDTH-1:0] mem [1 << `SRAM_ADDR_WIDTH];
    logic [`SRAM_DATA_WIDTH-1:0] rd_word;
    logic                        rd_en;
    logic [31:0]                 g;

    // Byte value from the array-wide byte offset
    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ {2'b00, a[21:16]} ^ 8'h3c;
    endfunction

    initial begin
        for (int i = 0; i < (1 << `SRAM_ADDR_WIDTH); i++) begin
            g = BANK * `SRAM_BANK_SPAN + 2 * i;
            mem[i[`SRAM_ADDR_WIDTH-1:0]] = {fill_byte(g + 32'd1), fill_byte(g)};
        end
    end

    // Disabled lanes read as zero
    assign rd_en   = !i_pins.ce_n && !i_pins.oe_n && i_pins.we_n &&
                     !(i_pins.ub_n && i_pins.lb_n);
    assign rd_word = {i_pins.ub_n ? 8'h00 : mem[i_pins.addr][15:8],
                      i_pins.lb_n ? 8'h00 : mem[i_pins.addr][7:0]};
    assign io_dq   = rd_en ? rd_word : 'z;

    always @(posedge i_wb_clk) begin
        if (!i_pins.ce_n && !i_pins.we_n) begin
            if (!i_pins.ub_n) begin
                mem[i_pins.addr][15:8] = io_dq[15:8];
            end
            if (!i_pins.lb_n) begin
                mem[i_pins.addr][7:0] = io_dq[7:0];
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/wb_sram_array.sv */
/* Wishbone pipelined slave over a bank of IS61WV102416 SRAM chips.
   Decoder, one controller per chip and the response merger */
`default_nettype none
`timescale 1ns/1ns

`include "sram_defs.svh"

module wb_sram_array
    import sram_pkg::*;
(
    input  logic                          i_wb_clk,
    input  logic                          i_wb_rst,
    input  logic                          i_wb_cyc,
    input  logic                          i_wb_stb,
    input  logic                          i_wb_we,
    input  logic [`SRAM_DATA_WIDTH/8-1:0] i_wb_sel,
    input  logic [`WB_ADDR_WIDTH-1:0]     i_wb_addr,
    input  logic [`SRAM_DATA_WIDTH-1:0]   i_wb_data,
    output logic [`SRAM_DATA_WIDTH-1:0]   o_wb_data,
    output logic                          o_wb_ack,
    output logic                          o_wb_stall,
    output sram_pins_t                    o_sram_pins [`SRAM_NUM_BANKS],
    inout  wire  [`SRAM_NUM_BANKS-1:0][`SRAM_DATA_WIDTH-1:0] io_sram_dq
);

    logic [`SRAM_NUM_BANKS-1:0] bank_full;
    logic [`SRAM_NUM_BANKS-1:0] req_we;
    sram_req_t                  req;        // Shared, req_we picks the bank
    sram_resp_t                 resp [`SRAM_NUM_BANKS];
    logic                       done;

    wb_bank_decode u_decode (
        .i_wb_clk    (i_wb_clk),
        .i_wb_rst    (i_wb_rst),
        .i_wb_cyc    (i_wb_cyc),
        .i_wb_stb    (i_wb_stb),
        .i_wb_we     (i_wb_we),
        .i_wb_sel    (i_wb_sel),
        .i_wb_addr   (i_wb_addr),
        .i_wb_data   (i_wb_data),
        .i_bank_full (bank_full),
        .i_done      (done),
        .o_req_we    (req_we),
        .o_req       (req),
        .o_wb_stall  (o_wb_stall)
    );

    for (genvar g = 0; g < `SRAM_NUM_BANKS; g++) begin : g_bank
        wb_sram_bank u_bank (
            .i_wb_clk   (i_wb_clk),
            .i_wb_rst   (i_wb_rst),
            .i_wb_cyc   (i_wb_cyc),
            .i_req_we   (req_we[g]),
            .i_req      (req),
            .o_full     (bank_full[g]),
            .o_resp     (resp[g]),
            .o_pins     (o_sram_pins[g]),
            .io_sram_dq (io_sram_dq[g])
        );
    end

    wb_resp_merge u_merge (
        .i_wb_clk  (i_wb_clk),
        .i_wb_rst  (i_wb_rst),
        .i_wb_cyc  (i_wb_cyc),
        .i_resp    (resp),
        .o_wb_ack  (o_wb_ack),
        .o_wb_data (o_wb_data),
        .o_done    (done)
    );

endmodule

`default_nettype wire

/* rtl/wb_resp_merge.sv */
/* Return path of the SRAM array. Registers the acknowledging bank's data onto
   the Wishbone bus and tells the decoder a request has completed */
`default_nettype none
`timescale 1ns/1ns

`include "sram_defs.svh"

module wb_resp_merge
    import sram_pkg::*;
(
    input  logic                        i_wb_clk,
    input  logic                        i_wb_rst,
    input  logic                        i_wb_cyc,
    input  sram_resp_t                  i_resp [`SRAM_NUM_BANKS],
    output logic                        o_wb_ack,
    output logic [`SRAM_DATA_WIDTH-1:0] o_wb_data,
    output logic                        o_done
);

    logic [`SRAM_NUM_BANKS-1:0]  bank_ack;
    logic [`SRAM_DATA_WIDTH-1:0] sel_data;
    logic                        ack_q;

    // Only one bank answers at a time, so an OR of masked data is enough
    always_comb begin
        sel_data = '0;
        for (int i = 0; i < `SRAM_NUM_BANKS; i++) begin
            bank_ack[i] = i_resp[i].ack;
            if (i_resp[i].ack) begin
                sel_data = sel_data | i_resp[i].data;
            end
        end
    end

    always_ff @(posedge i_wb_clk) begin
        if (i_wb_rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= (bank_ack != '0) && i_wb_cyc;
        end
    end

    always_ff @(posedge i_wb_clk) begin
        if (bank_ack != '0) begin
            o_wb_data <= sel_data;
        end
    end

    assign o_wb_ack = ack_q && i_wb_cyc;    // Dropped cycle gets no late ack
    assign o_done   = o_wb_ack;

    // Decoder stalls bank switches until the old bank has drained
    a_one_bank_acks: assert property (@(posedge i_wb_clk) disable iff (i_wb_rst)
        $onehot0(bank_ack));

endmodule

`default_nettype wire

/* rtl/wb_sram_bank.sv */
/* Controller for one asynchronous 16-bit SRAM chip. Queues decoder requests,
   runs one word access per clock and splits odd-address accesses in two */
`default_nettype none
`timescale 1ns/1ns

`include "sram_defs.svh"

module wb_sram_bank
    import sram_pkg::*;
(
    input  logic                        i_wb_clk,
    input  logic                        i_wb_rst,
    input  logic                        i_wb_cyc,
    input  logic                        i_req_we,
    input  sram_req_t                   i_req,
    output logic                        o_full,
    output sram_resp_t                  o_resp,
    output sram_pins_t                  o_pins,
    inout  wire  [`SRAM_DATA_WIDTH-1:0] io_sram_dq
);

    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_ACK0 = 2'b01,    // Head word, acks here when aligned
        ST_ACK1 = 2'b10     // Second word of an odd access
    } state_t;

    state_t                      state;
    state_t                      next_state;
    sram_req_t                   head;
    logic                        head_valid;
    logic                        unaligned;
    logic                        run0;
    logic                        run1;
    logic                        dq_oe;
    logic [`SRAM_DATA_WIDTH-1:0] dq_out;
    logic [7:0]                  byte_q;    // Byte carried into the second word
    logic [`SRAM_ADDR_WIDTH-1:0] addr_q;
    logic                        sel_q;
    logic                        we_q;

    sync_fifo u_fifo (
        .i_wb_clk (i_wb_clk),
        .i_wb_rst (i_wb_rst),
        .i_flush  (~i_wb_cyc),
        .i_we     (i_req_we),
        .i_data   (i_req),
        .i_ack    (run0),
        .o_data   (head),
        .o_valid  (head_valid),
        .o_full   (o_full)
    );

    assign unaligned = head.addr[0];

    // Nothing reaches the chip once CYC is gone
    assign run0 = (state == ST_ACK0) && head_valid && i_wb_cyc;
    assign run1 = (state == ST_ACK1) && i_wb_cyc;

    always_ff @(posedge i_wb_clk) begin
        if (i_wb_rst) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = ST_IDLE;
        case (state)
            ST_IDLE: begin
                if (head_valid && i_wb_cyc) begin
                    next_state = ST_ACK0;
                end
            end
            ST_ACK0: begin
                if (run0) begin
                    next_state = unaligned ? ST_ACK1 : ST_ACK0;
                end
            end
            ST_ACK1: begin
                if (head_valid && i_wb_cyc) begin  // Head already moved on
                    next_state = ST_ACK0;
                end
            end
            default: next_state = ST_IDLE;
        endcase
    end

    // Head is popped in ACK0, so ACK1 runs from these
    always_ff @(posedge i_wb_clk) begin
        if (run0 && unaligned) begin
            byte_q <= head.we ? head.data[15:8] : io_sram_dq[15:8];
            addr_q <= head.addr[`SRAM_ADDR_WIDTH:1] + 1'b1;
            sel_q  <= head.sel[1];
            we_q   <= head.we;
        end
    end

    always_comb begin
        o_pins.addr = '0;
        o_pins.we_n = 1'b1;
        o_pins.ub_n = 1'b1;         // Lanes off while idle
        o_pins.lb_n = 1'b1;
        o_pins.ce_n = 1'b0;
        o_pins.oe_n = 1'b0;
        if (run0) begin
            o_pins.addr = head.addr[`SRAM_ADDR_WIDTH:1];
            o_pins.we_n = ~head.we;
            if (unaligned) begin
                o_pins.ub_n = ~head.sel[0];     // Byte at the odd address
            end else begin
                o_pins.ub_n = ~head.sel[1];
                o_pins.lb_n = ~head.sel[0];
            end
        end else if (run1) begin
            o_pins.addr = addr_q;
            o_pins.lb_n = ~sel_q;
            o_pins.we_n = ~we_q;
        end
    end

    // Data pins driven only in write cycles
    assign dq_oe      = (run0 && head.we) || (run1 && we_q);
    assign dq_out     = run1      ? {8'h00, byte_q} :
                        unaligned ? {head.data[7:0], 8'h00} : head.data;
    assign io_sram_dq = dq_oe ? dq_out : 'z;

    always_comb begin
        o_resp.ack  = (run0 && !unaligned) || run1;
        o_resp.data = '0;
        if (run0 && !unaligned && !head.we) begin
            o_resp.data = io_sram_dq;
        end else if (run1 && !we_q) begin
            o_resp.data = {io_sram_dq[7:0], byte_q};   // Next word low lane on top
        end
    end

    a_state_legal: assert property (@(posedge i_wb_clk) disable iff (i_wb_rst)
        state inside {ST_IDLE, ST_ACK0, ST_ACK1});

endmodule

`default_nettype wire

/* rtl/wb_bank_decode.sv */
/* Front end of the SRAM array. Checks the bus address, picks the chip and
   hands a registered request to that bank, stalling to keep responses in order */
`default_nettype none
`timescale 1ns/1ns

`include "sram_defs.svh"

module wb_bank_decode
    import sram_pkg::*;
(
    input  logic                          i_wb_clk,
    input  logic                          i_wb_rst,
    input  logic                          i_wb_cyc,
    input  logic                          i_wb_stb,
    input  logic                          i_wb_we,
    input  logic [`SRAM_DATA_WIDTH/8-1:0] i_wb_sel,
    input  logic [`WB_ADDR_WIDTH-1:0]     i_wb_addr,
    input  logic [`SRAM_DATA_WIDTH-1:0]   i_wb_data,
    input  logic [`SRAM_NUM_BANKS-1:0]    i_bank_full,
    input  logic                          i_done,
    output logic [`SRAM_NUM_BANKS-1:0]    o_req_we,
    output sram_req_t                     o_req,
    output logic                          o_wb_stall
);

    localparam int OFS_W   = $clog2(`SRAM_BANK_SPAN);
    localparam int BANK_W  = $bits(bank_idx_t);
    localparam int CNT_MAX = `SRAM_FIFO_DEPTH;
    localparam int CNT_W   = $clog2(CNT_MAX) + 1;
    localparam logic [`WB_ADDR_WIDTH-1:0] SPAN_TOTAL = `SRAM_BANK_SPAN * `SRAM_NUM_BANKS;

    logic [`WB_ADDR_WIDTH-1:0] offset;
    logic                      cs;
    logic                      accept;
    bank_idx_t                 bank;
    bank_idx_t                 cur_bank;    // Owner of the in-flight requests
    logic [CNT_W-1:0]          inflight;

    assign offset = i_wb_addr - `SRAM_BASE_ADDR;
    assign cs     = (i_wb_addr >= `SRAM_BASE_ADDR) && (offset < SPAN_TOTAL);
    assign bank   = offset[OFS_W +: BANK_W];

    // Out-of-range strobes are taken and dropped, never stalled
    assign o_wb_stall = i_wb_cyc && i_wb_stb && cs &&
                        ((inflight != '0 && bank != cur_bank) ||
                         i_bank_full[bank] ||
                         inflight == CNT_W'(CNT_MAX));
    assign accept     = i_wb_cyc && i_wb_stb && cs && !o_wb_stall;

    always_ff @(posedge i_wb_clk) begin
        if (i_wb_rst) begin
            o_req_we <= '0;
            cur_bank <= '0;
        end else begin
            for (int i = 0; i < `SRAM_NUM_BANKS; i++) begin
                o_req_we[i] <= accept && (bank == bank_idx_t'(i));
            end
            if (accept) begin
                cur_bank <= bank;
            end
        end
    end

    always_ff @(posedge i_wb_clk) begin
        if (accept) begin
            o_req <= '{data: i_wb_data, addr: offset[`SRAM_ADDR_WIDTH:0],
                       sel: i_wb_sel, we: i_wb_we};
        end
    end

    // Banks flush when CYC falls, so the count starts over
    always_ff @(posedge i_wb_clk) begin
        if (i_wb_rst || !i_wb_cyc) begin
            inflight <= '0;
        end else begin
            case ({accept, i_done})
                2'b10:   inflight <= inflight + 1'b1;
                2'b01:   inflight <= inflight - 1'b1;
                default: inflight <= inflight;
            endcase
        end
    end

    // Every completion from the merger matches an accepted request
    a_done_counted: assert property (@(posedge i_wb_clk) disable iff (i_wb_rst)
        i_done |-> inflight != '0);

endmodule

`default_nettype wire

/* rtl/sync_fifo.sv */
/* Request queue in front of one SRAM chip. Head entry is readable
   combinationally while o_valid is high, i_ack pops it, i_flush empties it */
`default_nettype none
`timescale 1ns/1ns

`include "sram_defs.svh"

module sync_fifo
    import sram_pkg::*;
(
    input  logic      i_wb_clk,
    input  logic      i_wb_rst,
    input  logic      i_flush,
    input  logic      i_we,
    input  sram_req_t i_data,
    input  logic      i_ack,
    output sram_req_t o_data,
    output logic      o_valid,
    output logic      o_full
);

    localparam int DEPTH = `SRAM_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    sram_req_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    assign o_data  = mem[rd_ptr];
    assign o_valid = (count != '0);
    assign o_full  = (count == (PTR_W + 1)'(DEPTH));

    always_ff @(posedge i_wb_clk) begin
        if (i_we && !i_flush) begin
            mem[wr_ptr] <= i_data;
        end
    end

    // Pointers wrap on their own since depth is a power of two
    always_ff @(posedge i_wb_clk) begin
        if (i_wb_rst || i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_we) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_ack) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({i_we, i_ack})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Decoder in-flight limit keeps the queue from overrunning
    a_no_overflow: assert property (@(posedge i_wb_clk) disable iff (i_wb_rst)
        i_we |-> !o_full);

    // Sequencer only pops an entry it is working on
    a_no_underflow: assert property (@(posedge i_wb_clk) disable iff (i_wb_rst)
        i_ack |-> o_valid);

endmodule

`default_nettype wire

/* rtl/sram_pkg.sv */
/* Types shared by the SRAM bank array. A request travels from the decoder
   to one bank, a response from each bank to the merger */
`default_nettype none

`include "sram_defs.svh"

package sram_pkg;

    // Enough bits to number every chip
    typedef logic [(`SRAM_NUM_BANKS > 1 ? $clog2(`SRAM_NUM_BANKS) : 1)-1:0] bank_idx_t;

    typedef struct packed {
        logic [`SRAM_DATA_WIDTH-1:0]   data;    // Write data
        logic [`SRAM_ADDR_WIDTH:0]     addr;    // Byte address inside the bank
        logic [`SRAM_DATA_WIDTH/8-1:0] sel;
        logic                          we;
    } sram_req_t;

    typedef struct packed {
        logic                          ack;     // One cycle per finished request
        logic [`SRAM_DATA_WIDTH-1:0]   data;
    } sram_resp_t;

    // Chip control pins, all active low
    typedef struct packed {
        logic [`SRAM_ADDR_WIDTH-1:0]   addr;
        logic                          we_n;
        logic                          ub_n;
        logic                          lb_n;
        logic                          ce_n;
        logic                          oe_n;
    } sram_pins_t;

endpackage

`default_nettype wire

/* include/sram_defs.svh */
/* Build constants for the Wishbone SRAM bank array.
   Included by the package and by every module that sizes ports from them */

`ifndef SRAM_DEFS_SVH
`define SRAM_DEFS_SVH

// One IS61WV102416 chip
`define SRAM_DATA_WIDTH 16          // Chip data bus
`define SRAM_ADDR_WIDTH 20          // Word address, 1M words
`define SRAM_BANK_SPAN  2097152     // Bytes per chip

// Bank layout on the bus
`define SRAM_NUM_BANKS  2
`define SRAM_BASE_ADDR  32'h0400_0000   // Byte address of bank 0, banks follow back to back

// Wishbone side
`define WB_ADDR_WIDTH   32

// Request queue per chip, also the limit on requests in flight
`define SRAM_FIFO_DEPTH 8           // Power of two

`endif
